/* project.f */
rtl/uart_pkg.sv
rtl/byte_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_core.sv
rtl/uart_regs.sv
rtl/uart_top.sv
bench/clock_gen.sv
bench/uart_checker.sv
bench/uart_assertions.sv
bench/uart_tb.sv

/* bench/uart_tb.sv */
`timescale 1ns/100ps

module uart_tb;

    import uart_pkg::*;

    typedef enum logic [2:0] {
        op_wr, op_rd, op_poll, op_send, op_push, op_drop, op_frame
    } op_t;

    typedef struct packed {
        op_t op;
        logic [1:0] adr;
        logic [7:0] wdata;
        logic [7:0] rdata;
        logic [7:0] mask;
    } step_t;

    logic clk;
    logic nreset;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic tx;
    logic rx;
    logic [DIV_BITS-1:0] cur_div;
    logic [31:0] seed_val;
    step_t steps [$];

    clock_gen clocks (.clk(clk), .nreset(nreset));

    uart_top uut (
        .clk(clk),
        .nreset(nreset),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .tx(tx),
        .rx(rx)
    );

    uart_checker chk (.clk(clk), .tx(tx), .wb_rsp(wb_rsp), .bit_cycles(cur_div));

    // ====================
    // Bus and line tasks
    // ====================
    task automatic bus_access(input logic we, input logic [1:0] adr, input logic [7:0] wdata,
                              input logic [7:0] want, input logic [7:0] mask,
                              output logic [7:0] rdata);
        int n;
        @(negedge clk);
        if (!we)
            chk.expect_read(want, mask);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = we;
        wb_req.adr = adr;
        wb_req.dat_w = wdata;
        n = 0;
        rdata = 8'h00;
        while (wb_rsp.ack !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (wb_rsp.ack === 1'b1)
            rdata = wb_rsp.dat_r;
        else
            chk.note_timeout("bus access got no ack");
        wb_req = '0;
    endtask

    task automatic poll_reg(input logic [1:0] adr, input logic [7:0] mask,
                            input logic [7:0] want);
        int n;
        logic [7:0] d;
        n = 0;
        do begin
            bus_access(1'b0, adr, 8'h00, 8'h00, 8'h00, d);
            n++;
        end while ((d & mask) != want && n < 2000);
        if ((d & mask) != want)
            chk.note_timeout("register poll never reached the awaited value");
    endtask

    task automatic drive_frame(input logic [7:0] b);
        logic [9:0] frame;
        int i;
        frame = {1'b1, b, 1'b0};
        @(negedge clk);
        for (i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (cur_div) @(negedge clk);
        end
    endtask

    task automatic run_step(input step_t s);
        logic [7:0] d;
        case (s.op)
            op_wr: begin
                bus_access(1'b1, s.adr, s.wdata, 8'h00, 8'h00, d);
                if (s.adr == ADDR_DIV_LO)
                    cur_div[7:0] = s.wdata;
                if (s.adr == ADDR_DIV_HI)
                    cur_div[DIV_BITS-1:8] = s.wdata;
            end
            op_rd: bus_access(1'b0, s.adr, 8'h00, s.rdata, s.mask, d);
            op_poll: poll_reg(s.adr, s.mask, s.rdata);
            op_send: begin
                // Room in the transmit FIFO first
                poll_reg(ADDR_STATUS, 8'h08, 8'h00);
                chk.expect_tx(s.wdata);
                bus_access(1'b1, ADDR_DATA, s.wdata, 8'h00, 8'h00, d);
            end
            op_push: begin
                chk.expect_tx(s.wdata);
                bus_access(1'b1, ADDR_DATA, s.wdata, 8'h00, 8'h00, d);
            end
            op_drop: bus_access(1'b1, ADDR_DATA, s.wdata, 8'h00, 8'h00, d);
            default: drive_frame(s.wdata);
        endcase
    endtask

    // ====================
    // Stimulus table
    // ====================
    task automatic add_step(input op_t op, input logic [1:0] adr, input logic [7:0] wdata,
                            input logic [7:0] rdata, input logic [7:0] mask);
        step_t s;
        s = '{op, adr, wdata, rdata, mask};
        steps.push_back(s);
    endtask

    task automatic build_steps();
        logic [7:0] rx_bytes [3];
        logic [7:0] fill [2**RX_FIFO_BITS + 2];
        logic [31:0] r;
        int i;
        rx_bytes = '{8'ha7, 8'h01, 8'h80};
        // After reset: tx_empty and rx_empty only
        add_step(op_rd, ADDR_STATUS, 8'h00, 8'h05, 8'hff);
        add_step(op_rd, ADDR_DIV_LO, 8'h00, DIV_RESET[7:0], 8'hff);
        add_step(op_rd, ADDR_DIV_HI, 8'h00, DIV_RESET[DIV_BITS-1:8], 8'hff);
        // Divisor read back, then 16 cycles per bit
        add_step(op_wr, ADDR_DIV_LO, 8'ha5, 8'h00, 8'h00);
        add_step(op_wr, ADDR_DIV_HI, 8'h5a, 8'h00, 8'h00);
        add_step(op_rd, ADDR_DIV_LO, 8'h00, 8'ha5, 8'hff);
        add_step(op_rd, ADDR_DIV_HI, 8'h00, 8'h5a, 8'hff);
        add_step(op_wr, ADDR_DIV_LO, 8'h10, 8'h00, 8'h00);
        add_step(op_wr, ADDR_DIV_HI, 8'h00, 8'h00, 8'h00);
        add_step(op_rd, ADDR_DIV_LO, 8'h00, 8'h10, 8'hff);
        add_step(op_rd, ADDR_DIV_HI, 8'h00, 8'h00, 8'hff);
        add_step(op_send, ADDR_DATA, 8'h96, 8'h00, 8'h00);
        // Transmit
        add_step(op_send, ADDR_DATA, 8'h55, 8'h00, 8'h00);
        add_step(op_send, ADDR_DATA, 8'h00, 8'h00, 8'h00);
        add_step(op_send, ADDR_DATA, 8'hff, 8'h00, 8'h00);
        for (i = 0; i < 3; i++) begin
            r = $urandom;
            add_step(op_send, ADDR_DATA, r[7:0], 8'h00, 8'h00);
        end
        add_step(op_poll, ADDR_STATUS, 8'h00, 8'h04, 8'h14);
        // Receive
        for (i = 0; i < 3; i++) begin
            add_step(op_frame, ADDR_DATA, rx_bytes[i], 8'h00, 8'h00);
            add_step(op_poll, ADDR_STATUS, 8'h00, 8'h00, 8'h01);
            add_step(op_rd, ADDR_DATA, 8'h00, rx_bytes[i], 8'hff);
        end
        add_step(op_rd, ADDR_DATA, 8'h00, 8'h00, 8'hff);
        // Transmit overflow, depth plus one bytes leave
        for (i = 0; i < 2**TX_FIFO_BITS + 3; i++) begin
            r = $urandom;
            if (i < 2**TX_FIFO_BITS + 1)
                add_step(op_push, ADDR_DATA, r[7:0], 8'h00, 8'h00);
            else
                add_step(op_drop, ADDR_DATA, r[7:0], 8'h00, 8'h00);
        end
        // tx_overflow, tx_busy, tx_full, rx_empty
        add_step(op_rd, ADDR_STATUS, 8'h00, 8'h59, 8'hff);
        add_step(op_rd, ADDR_STATUS, 8'h00, 8'h00, 8'h40);
        add_step(op_poll, ADDR_STATUS, 8'h00, 8'h04, 8'h14);
        // Receive overrun
        for (i = 0; i < 2**RX_FIFO_BITS + 2; i++) begin
            r = $urandom;
            fill[i] = r[7:0];
            add_step(op_frame, ADDR_DATA, fill[i], 8'h00, 8'h00);
        end
        add_step(op_poll, ADDR_STATUS, 8'h00, 8'h22, 8'h22);
        add_step(op_rd, ADDR_STATUS, 8'h00, 8'h02, 8'h23);
        for (i = 0; i < 2**RX_FIFO_BITS; i++)
            add_step(op_rd, ADDR_DATA, 8'h00, fill[i], 8'hff);
        add_step(op_rd, ADDR_DATA, 8'h00, 8'h00, 8'hff);
        add_step(op_rd, ADDR_STATUS, 8'h00, 8'h01, 8'h23);
    endtask

    initial begin
        int n;
        seed_val = $urandom(32'hd2e6d7ee);
        wb_req = '0;
        rx = 1'b1;
        cur_div = DIV_RESET;
        build_steps();
        n = 0;
        while (nreset !== 1'b1 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (nreset !== 1'b1)
            chk.note_timeout("reset was never released");
        chk.check_tx_idle();
        foreach (steps[i])
            run_step(steps[i]);
        n = 0;
        while (chk.pending_tx() != 0 && n < 4000) begin
            @(negedge clk);
            n++;
        end
        if (chk.pending_tx() != 0)
            chk.note_timeout("expected bytes never appeared on tx");
        $display("mismatches %0d, timeouts %0d, assertion failures %0d",
                 chk.mismatches, chk.timeouts, uut.bus_line_props.failures);
        if (chk.mismatches == 0 && chk.timeouts == 0 && uut.bus_line_props.failures == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* bench/uart_assertions.sv */
`timescale 1ns/100ps

module uart_assertions (
    input logic              clk,
    input logic              nreset,
    input uart_pkg::wb_req_t wb_req,
    input uart_pkg::wb_rsp_t wb_rsp,
    input logic              tx,
    input logic              tx_busy
);

    int failures = 0;

    ack_after_request: assert property (@(posedge clk) disable iff (!nreset)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            $error("ack without cyc and stb in the previous cycle");
            failures++;
        end

    ack_single_cycle: assert property (@(posedge clk) disable iff (!nreset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("ack held for two cycles");
            failures++;
        end

    line_idle_high: assert property (@(posedge clk) disable iff (!nreset)
        !tx_busy |-> tx)
        else begin
            $error("tx low while the transmitter is idle");
            failures++;
        end

    dat_r_zero: assert property (@(posedge clk) disable iff (!nreset)
        !wb_rsp.ack |-> wb_rsp.dat_r == 8'h00)
        else begin
            $error("dat_r not zero without ack");
            failures++;
        end

endmodule

bind uart_top uart_assertions bus_line_props (
    .clk(clk),
    .nreset(nreset),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp),
    .tx(tx),
    .tx_busy(stat.tx_busy)
);

/* bench/uart_checker.sv */
`timescale 1ns/100ps

module uart_checker (
    input logic                          clk,
    input logic                          tx,
    input uart_pkg::wb_rsp_t             wb_rsp,
    input logic [uart_pkg::DIV_BITS-1:0] bit_cycles
);

    typedef struct packed {
        logic [7:0] data;
        logic [7:0] mask;
    } read_exp_t;

    int mismatches = 0;
    int timeouts = 0;
    logic [7:0] tx_queue [$];
    read_exp_t read_queue [$];
    read_exp_t head;
    logic tx_last;

    task automatic expect_tx(input logic [7:0] b);
        tx_queue.push_back(b);
    endtask

    task automatic expect_read(input logic [7:0] data, input logic [7:0] mask);
        read_exp_t e;
        e.data = data;
        e.mask = mask;
        read_queue.push_back(e);
    endtask

    task automatic note_timeout(input string msg);
        $display("Timeout at %0t: %s", $time, msg);
        timeouts++;
    endtask

    task automatic check_tx_idle();
        if (tx !== 1'b1) begin
            $display("error at %0t: tx is %b on an idle line, expected 1", $time, tx);
            mismatches++;
        end
    endtask

    function automatic int pending_tx();
        return tx_queue.size();
    endfunction

    // ====================
    // Serial line decoder
    // ====================
    // Cycle k of the frame is seen at the k-th falling clock edge
    task automatic decode_frame();
        int div;
        int k;
        logic prev;
        logic [9:0] bits;
        logic [7:0] want;
        div = bit_cycles;
        prev = 1'b0;
        bits = '1;
        for (k = 1; k <= 10 * div; k++) begin
            if (k > 1)
                @(negedge clk);
            // Every edge has to sit on the bit grid
            if (tx !== prev && (k - 1) % div != 0) begin
                $display("error at %0t: tx edge %0d cycles into a frame, bit length %0d",
                         $time, k - 1, div);
                mismatches++;
            end
            prev = tx;
            if (k % div == div / 2)
                bits[k / div] = tx;
        end
        if (bits[0] !== 1'b0 || bits[9] !== 1'b1) begin
            $display("error at %0t: bad start or stop bit on tx", $time);
            mismatches++;
        end
        if (tx_queue.size() == 0) begin
            $display("error at %0t: byte %02h on tx with none expected", $time, bits[8:1]);
            mismatches++;
        end else begin
            want = tx_queue.pop_front();
            if (bits[8:1] !== want) begin
                $display("error at %0t: tx byte %02h, expected %02h", $time, bits[8:1], want);
                mismatches++;
            end
        end
    endtask

    initial begin
        tx_last = 1'b1;
        forever begin
            @(negedge clk);
            if (tx_last === 1'b1 && tx === 1'b0)
                decode_frame();
            tx_last = tx;
        end
    end

    // ====================
    // Bus read data
    // ====================
    always @(negedge clk) begin
        if (wb_rsp.ack === 1'b1 && read_queue.size() != 0) begin
            head = read_queue.pop_front();
            if ((wb_rsp.dat_r & head.mask) !== (head.data & head.mask)) begin
                $display("error at %0t: read %02h, expected %02h under mask %02h",
                         $time, wb_rsp.dat_r, head.data, head.mask);
                mismatches++;
            end
        end
    end

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic nreset
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        nreset = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        nreset = 1'b1;
    end

endmodule

/* rtl/uart_top.sv */
`timescale 1ns/100ps

module uart_top (
    input  logic              clk,
    input  logic              nreset,
    input  uart_pkg::wb_req_t wb_req,
    output uart_pkg::wb_rsp_t wb_rsp,
    output logic              tx,
    input  logic              rx
);

    import uart_pkg::*;

    core_ctrl_t ctrl;
    core_stat_t stat;

    uart_regs u_regs (
        .clk(clk),
        .nreset(nreset),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .ctrl(ctrl),
        .stat(stat)
    );

    uart_core u_core (
        .clk(clk),
        .nreset(nreset),
        .ctrl(ctrl),
        .stat(stat),
        .tx(tx),
        .rx(rx)
    );

endmodule

/* rtl/uart_regs.sv */
`timescale 1ns/100ps

module uart_regs (
    input  logic                 clk,
    input  logic                 nreset,
    input  uart_pkg::wb_req_t    wb_req,
    output uart_pkg::wb_rsp_t    wb_rsp,
    output uart_pkg::core_ctrl_t ctrl,
    input  uart_pkg::core_stat_t stat
);

    import uart_pkg::*;

    logic ack;
    logic [7:0] dat_r;
    logic [DIV_BITS-1:0] divisor;
    logic tx_push;
    logic [7:0] tx_byte;
    logic rx_pop;
    logic rx_overrun;
    logic tx_overflow;
    logic accept;
    logic wr_data;
    logic rd_data;
    logic rd_status;
    uart_status_t status;
    logic [7:0] rd_word;

    // Only the first cycle of a request is taken
    assign accept = wb_req.cyc && wb_req.stb && !ack;
    assign wr_data = accept && wb_req.we && wb_req.adr == ADDR_DATA;
    assign rd_data = accept && !wb_req.we && wb_req.adr == ADDR_DATA;
    assign rd_status = accept && !wb_req.we && wb_req.adr == ADDR_STATUS;

    assign status.reserved = 1'b0;
    assign status.tx_overflow = tx_overflow;
    assign status.rx_overrun = rx_overrun;
    assign status.tx_busy = stat.tx_busy;
    assign status.tx_full = stat.tx_full;
    assign status.tx_empty = stat.tx_empty;
    assign status.rx_full = stat.rx_full;
    assign status.rx_empty = stat.rx_empty;

    always_comb begin
        case (wb_req.adr)
            ADDR_DATA: rd_word = stat.rx_empty ? 8'h00 : stat.rx_byte;
            ADDR_STATUS: rd_word = status;
            ADDR_DIV_LO: rd_word = divisor[7:0];
            default: rd_word = divisor[DIV_BITS-1:8];
        endcase
    end

    // ====================
    // Bus response, pulses and flags
    // ====================
    always_ff @(posedge clk) begin
        if (!nreset) begin
            ack <= 1'b0;
            dat_r <= 8'h00;
            divisor <= DIV_RESET;
            tx_push <= 1'b0;
            rx_pop <= 1'b0;
            rx_overrun <= 1'b0;
            tx_overflow <= 1'b0;
        end else begin
            ack <= accept;
            dat_r <= (accept && !wb_req.we) ? rd_word : 8'h00;
            tx_push <= wr_data && !stat.tx_full;
            rx_pop <= rd_data && !stat.rx_empty;
            if (accept && wb_req.we && wb_req.adr == ADDR_DIV_LO)
                divisor[7:0] <= wb_req.dat_w;
            if (accept && wb_req.we && wb_req.adr == ADDR_DIV_HI)
                divisor[DIV_BITS-1:8] <= wb_req.dat_w;
            // New events win over the clear on read
            rx_overrun <= stat.rx_drop || (rx_overrun && !rd_status);
            tx_overflow <= (wr_data && stat.tx_full) || (tx_overflow && !rd_status);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_data)
            tx_byte <= wb_req.dat_w;
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat_r = dat_r;

    assign ctrl.divisor = divisor;
    assign ctrl.tx_push = tx_push;
    assign ctrl.tx_byte = tx_byte;
    assign ctrl.rx_pop = rx_pop;

endmodule

/* rtl/uart_core.sv */
`timescale 1ns/100ps

module uart_core (
    input  logic                 clk,
    input  logic                 nreset,
    input  uart_pkg::core_ctrl_t ctrl,
    output uart_pkg::core_stat_t stat,
    output logic                 tx,
    input  logic                 rx
);

    import uart_pkg::*;

    logic [7:0] tx_head;
    logic [7:0] tx_byte_q;
    logic tx_empty;
    logic tx_full;
    logic tx_pop;
    logic tx_busy;
    logic start_q;
    logic [7:0] rx_data;
    logic rx_valid;
    logic rx_empty;
    logic rx_full;
    logic rx_push_q;
    logic rx_drop_q;

    byte_fifo #(.addr_bits(TX_FIFO_BITS)) tx_fifo (
        .clk(clk), .nreset(nreset),
        .push(ctrl.tx_push), .wdata(ctrl.tx_byte),
        .pop(tx_pop), .rdata(tx_head),
        .full(tx_full), .empty(tx_empty)
    );

    byte_fifo #(.addr_bits(RX_FIFO_BITS)) rx_fifo (
        .clk(clk), .nreset(nreset),
        .push(rx_push_q), .wdata(rx_data),
        .pop(ctrl.rx_pop), .rdata(stat.rx_byte),
        .full(rx_full), .empty(rx_empty)
    );

    uart_tx u_tx (
        .clk(clk), .nreset(nreset), .divisor(ctrl.divisor),
        .start(start_q), .data(tx_byte_q), .busy(tx_busy), .tx(tx)
    );

    uart_rx u_rx (
        .clk(clk), .nreset(nreset), .divisor(ctrl.divisor),
        .rx(rx), .valid(rx_valid), .data(rx_data)
    );

    // Head of the FIFO goes to an idle transmitter
    assign tx_pop = !tx_busy && !start_q && !tx_empty;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            start_q <= 1'b0;
            rx_push_q <= 1'b0;
            rx_drop_q <= 1'b0;
        end else begin
            start_q <= tx_pop;
            rx_push_q <= rx_valid && !rx_full;
            rx_drop_q <= rx_valid && rx_full;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_pop)
            tx_byte_q <= tx_head;
    end

    assign stat.rx_empty = rx_empty;
    assign stat.rx_full = rx_full;
    assign stat.tx_empty = tx_empty;
    assign stat.tx_full = tx_full;
    assign stat.tx_busy = tx_busy || start_q;
    assign stat.rx_drop = rx_drop_q;

endmodule

/* rtl/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
    input  logic                          clk,
    input  logic                          nreset,
    input  logic [uart_pkg::DIV_BITS-1:0] divisor,
    input  logic                          rx,
    output logic                          valid,
    output logic [7:0]                    data
);

    import uart_pkg::*;

    logic rx_meta;
    logic rx_s;
    logic rx_prev;
    logic active;
    // 0 start check, 1 to 8 data, 9 stop
    logic [3:0] bit_idx;
    logic [DIV_BITS-1:0] cnt;
    logic [DIV_BITS-1:0] div_q;
    logic [DIV_BITS-1:0] target;

    // Half a bit to the start centre, then whole bits
    assign target = (bit_idx == 4'd0) ? {1'b0, div_q[DIV_BITS-1:1]} : div_q;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            rx_meta <= 1'b1;
            rx_s <= 1'b1;
            rx_prev <= 1'b1;
            active <= 1'b0;
            bit_idx <= '0;
            cnt <= '0;
            div_q <= '0;
            valid <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_s <= rx_meta;
            rx_prev <= rx_s;
            valid <= 1'b0;
            if (!active) begin
                if (rx_prev && !rx_s) begin
                    active <= 1'b1;
                    bit_idx <= '0;
                    cnt <= '0;
                    div_q <= divisor;
                end
            end else if (cnt == target - 1'b1) begin
                cnt <= '0;
                if (bit_idx == 4'd0) begin
                    // Glitch, not a start bit
                    if (rx_s)
                        active <= 1'b0;
                    else
                        bit_idx <= 4'd1;
                end else if (bit_idx != 4'd9) begin
                    bit_idx <= bit_idx + 1'b1;
                end else begin
                    active <= 1'b0;
                    valid <= rx_s;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Shift register, frozen from the stop bit to the next frame
    always_ff @(posedge clk) begin
        if (active && cnt == target - 1'b1 && bit_idx != 4'd0 && bit_idx != 4'd9)
            data <= {rx_s, data[7:1]};
    end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx (
    input  logic                          clk,
    input  logic                          nreset,
    input  logic [uart_pkg::DIV_BITS-1:0] divisor,
    input  logic                          start,
    input  logic [7:0]                    data,
    output logic                          busy,
    output logic                          tx
);

    import uart_pkg::*;

    logic [9:0] frame;
    logic [3:0] bit_idx;
    logic [DIV_BITS-1:0] cnt;
    // Divisor held for the whole frame
    logic [DIV_BITS-1:0] div_q;

    // Idle frame is all ones, so the line rests high
    assign tx = frame[0];

    always_ff @(posedge clk) begin
        if (!nreset) begin
            frame <= '1;
            bit_idx <= '0;
            cnt <= '0;
            div_q <= '0;
            busy <= 1'b0;
        end else if (!busy) begin
            if (start) begin
                // Stop, data LSB first, start
                frame <= {1'b1, data, 1'b0};
                bit_idx <= '0;
                cnt <= '0;
                div_q <= divisor;
                busy <= 1'b1;
            end
        end else if (cnt == div_q - 1'b1) begin
            cnt <= '0;
            frame <= {1'b1, frame[9:1]};
            if (bit_idx == 4'd9)
                busy <= 1'b0;
            else
                bit_idx <= bit_idx + 1'b1;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

/* rtl/byte_fifo.sv */
`timescale 1ns/100ps

module byte_fifo #(
    parameter int addr_bits = 2
) (
    input  logic       clk,
    input  logic       nreset,
    input  logic       push,
    input  logic [7:0] wdata,
    input  logic       pop,
    output logic [7:0] rdata,
    output logic       full,
    output logic       empty
);

    logic [7:0] mem [2**addr_bits];
    // Extra top bit tells a full buffer from an empty one
    logic [addr_bits:0] wptr;
    logic [addr_bits:0] rptr;
    logic do_push;
    logic do_pop;

    assign empty = (wptr == rptr);
    assign full = (wptr[addr_bits] != rptr[addr_bits]) &&
                  (wptr[addr_bits-1:0] == rptr[addr_bits-1:0]);

    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // Show-ahead head word
    assign rdata = mem[rptr[addr_bits-1:0]];

    always_ff @(posedge clk) begin
        if (!nreset) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (do_push)
                wptr <= wptr + 1'b1;
            if (do_pop)
                rptr <= rptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wptr[addr_bits-1:0]] <= wdata;
    end

endmodule

/* rtl/uart_pkg.sv */
package uart_pkg;

    // ====================
    // Sizes and reset values
    // ====================
    localparam int DIV_BITS = 16;
    // Clock cycles per bit after reset
    localparam logic [DIV_BITS-1:0] DIV_RESET = 16'd234;
    localparam int RX_FIFO_BITS = 3;
    localparam int TX_FIFO_BITS = 2;

    // Register map
    localparam logic [1:0] ADDR_DATA = 2'd0;
    localparam logic [1:0] ADDR_STATUS = 2'd1;
    localparam logic [1:0] ADDR_DIV_LO = 2'd2;
    localparam logic [1:0] ADDR_DIV_HI = 2'd3;

    // ====================
    // Bus and core bundles
    // ====================
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [1:0] adr;
        logic [7:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        logic [7:0] dat_r;
    } wb_rsp_t;

    // STATUS word, rx_empty is bit 0
    typedef struct packed {
        logic reserved;
        logic tx_overflow;
        logic rx_overrun;
        logic tx_busy;
        logic tx_full;
        logic tx_empty;
        logic rx_full;
        logic rx_empty;
    } uart_status_t;

    typedef struct packed {
        logic [DIV_BITS-1:0] divisor;
        logic tx_push;
        logic [7:0] tx_byte;
        logic rx_pop;
    } core_ctrl_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic rx_empty;
        logic rx_full;
        logic tx_empty;
        logic tx_full;
        logic tx_busy;
        logic rx_drop;
    } core_stat_t;

endpackage
